// ==== memtest_macros.svh ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// memory tester sizes and limits
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`ifndef MEMTEST_MACROS_SVH
`define MEMTEST_MACROS_SVH

// word address width, 64 words in simulation
`define MT_ADDR_W 6

`define MT_DATA_W 32

// cycles to wait for ack before giving up
`define MT_TIMEOUT 16

`define MT_ERR_W 16  // saturating error counter

// heartbeat counter, top bit drives the output
`define MT_HB_W 4

`endif

// ==== memtest_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// memory tester shared types
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

`include "memtest_macros.svh"

package memtest_pkg;

  // test word, seen either as a raw bus word or as tag + address echo
  typedef union packed {
    logic [`MT_DATA_W-1:0] raw;
    struct packed {
      logic [7:0]            tag;   // upper byte
      logic [`MT_DATA_W-9:0] echo;  // zero-extended word address
    } f;
  } mt_word_u;

endpackage

`default_nettype wire

// ==== test_seq_fsm.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// memory test sequencer
// fill/check passes, one access per address
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module test_seq_fsm (
  input  logic clk,
  input  logic rst_n,
  input  logic start,
  input  logic last_addr,
  input  logic acc_done,
  output logic acc_req,
  output logic acc_we,
  output logic pass_start,
  output logic inverted,
  output logic checking,
  output logic busy,
  output logic ended
);

  // launch state issues the request, wait state holds until done
  localparam logic [3:0] S_IDLE    = 4'd0;
  localparam logic [3:0] S_FILL0_L = 4'd1;
  localparam logic [3:0] S_FILL0_W = 4'd2;
  localparam logic [3:0] S_CHK0_L  = 4'd3;
  localparam logic [3:0] S_CHK0_W  = 4'd4;
  localparam logic [3:0] S_FILL1_L = 4'd5;
  localparam logic [3:0] S_FILL1_W = 4'd6;
  localparam logic [3:0] S_CHK1_L  = 4'd7;
  localparam logic [3:0] S_CHK1_W  = 4'd8;
  localparam logic [3:0] S_DONE    = 4'd9;

  logic [3:0] state;
  logic [3:0] state_nxt;
  logic       pass_end;

  assign pass_end = acc_done & last_addr;

  always_comb begin
    state_nxt = state;
    case (state)
      S_IDLE, S_DONE: if (start) state_nxt = S_FILL0_L;
      S_FILL0_L:      state_nxt = S_FILL0_W;
      S_CHK0_L:       state_nxt = S_CHK0_W;
      S_FILL1_L:      state_nxt = S_FILL1_W;
      S_CHK1_L:       state_nxt = S_CHK1_W;
      S_FILL0_W:      if (acc_done) state_nxt = last_addr ? S_CHK0_L : S_FILL0_L;
      S_CHK0_W:       if (acc_done) state_nxt = last_addr ? S_FILL1_L : S_CHK0_L;
      S_FILL1_W:      if (acc_done) state_nxt = last_addr ? S_CHK1_L : S_FILL1_L;
      S_CHK1_W:       if (acc_done) state_nxt = last_addr ? S_DONE : S_CHK1_L;
      default:        state_nxt = S_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= S_IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  assign busy  = (state != S_IDLE) && (state != S_DONE);
  assign ended = (state == S_DONE);

  assign acc_req = (state == S_FILL0_L) || (state == S_CHK0_L) ||
                   (state == S_FILL1_L) || (state == S_CHK1_L);
  assign acc_we  = (state == S_FILL0_L) || (state == S_FILL1_L);

  // accepted start, or the last done of any pass but check-1
  assign pass_start = (!busy && start) ||
                      (pass_end && ((state == S_FILL0_W) || (state == S_CHK0_W) ||
                                    (state == S_FILL1_W)));

  assign inverted = (state >= S_FILL1_L) && (state <= S_CHK1_W);
  assign checking = (state == S_CHK0_L) || (state == S_CHK0_W) ||
                    (state == S_CHK1_L) || (state == S_CHK1_W);

endmodule

`default_nettype wire

// ==== addr_counter.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// word address counter for one test pass
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

`include "memtest_macros.svh"

module addr_counter (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  clear,
  input  logic                  step,
  output logic [`MT_ADDR_W-1:0] addr,
  output logic                  last_addr
);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      addr <= '0;
    end else if (clear) begin  // clear wins over step
      addr <= '0;
    end else if (step) begin
      addr <= addr + 1'b1;     // wraps after the top word
    end
  end

  assign last_addr = &addr;

endmodule

`default_nettype wire

// ==== wb_master.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// wishbone classic master, one access at a time
// gives up after MT_TIMEOUT cycles without ack
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

`include "memtest_macros.svh"

module wb_master (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  req,
  input  logic                  we,
  input  logic [`MT_ADDR_W-1:0] addr,
  input  memtest_pkg::mt_word_u wdata,
  output logic                  done,
  output logic                  timed_out,
  output memtest_pkg::mt_word_u rdata,
  output logic                  wb_cyc,
  output logic                  wb_stb,
  output logic                  wb_we,
  output logic [`MT_ADDR_W-1:0] wb_adr,
  output logic [`MT_DATA_W-1:0] wb_dat_o,
  input  logic [`MT_DATA_W-1:0] wb_dat_i,
  input  logic                  wb_ack
);

  localparam int WAIT_W = $clog2(`MT_TIMEOUT);

  logic [WAIT_W-1:0] wait_cnt;  // stb cycles without ack
  logic              expired;

  assign expired = (wait_cnt == WAIT_W'(`MT_TIMEOUT - 1));

  // control
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wb_cyc    <= 1'b0;
      wb_stb    <= 1'b0;
      wb_we     <= 1'b0;
      wait_cnt  <= '0;
      done      <= 1'b0;
      timed_out <= 1'b0;
    end else begin
      done <= 1'b0;
      if (!wb_cyc) begin
        if (req) begin
          wb_cyc   <= 1'b1;
          wb_stb   <= 1'b1;
          wb_we    <= we;
          wait_cnt <= '0;
        end
      end else if (wb_ack || expired) begin
        wb_cyc    <= 1'b0;
        wb_stb    <= 1'b0;
        wb_we     <= 1'b0;
        done      <= 1'b1;
        timed_out <= !wb_ack;  // ack in the last cycle still counts
      end else begin
        wait_cnt <= wait_cnt + 1'b1;
      end
    end
  end

  // bus payload, held for the whole access
  always_ff @(posedge clk) begin
    if (!wb_cyc && req) begin
      wb_adr   <= addr;
      wb_dat_o <= wdata.raw;
    end
    if (wb_cyc && wb_ack) begin
      rdata.raw <= wb_dat_i;
    end else if (wb_cyc && expired) begin
      rdata.raw <= '0;  // nothing came back
    end
  end

endmodule

`default_nettype wire

// ==== pattern_engine.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// test pattern generator and read checker
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

`include "memtest_macros.svh"

module pattern_engine (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  clear,
  input  logic [`MT_ADDR_W-1:0] addr,
  input  logic                  inverted,
  input  logic                  checking,
  input  logic                  acc_done,
  input  logic                  timed_out,
  input  memtest_pkg::mt_word_u rdata,
  output memtest_pkg::mt_word_u wdata,
  output logic [`MT_ERR_W-1:0]  err_count,
  output logic                  test_error,
  output logic [`MT_ADDR_W-1:0] fail_addr
);

  import memtest_pkg::*;

  mt_word_u pat;  // pass-0 word for this address
  logic     err_hit;

  always_comb begin
    pat.f.tag                   = 8'hA5;
    pat.f.echo                  = '0;
    pat.f.echo[`MT_ADDR_W-1:0]  = addr;
  end

  assign wdata.raw = inverted ? ~pat.raw : pat.raw;

  // a timeout always counts, a read only in a check pass
  assign err_hit = acc_done &&
                   (timed_out || (checking && (rdata.raw != wdata.raw)));

  always_ff @(posedge clk) begin
    if (!rst_n || clear) begin
      err_count  <= '0;
      test_error <= 1'b0;
    end else if (err_hit) begin
      if (err_count != '1) begin
        err_count <= err_count + 1'b1;
      end
      test_error <= 1'b1;
    end
  end

  // first failing address of the run
  always_ff @(posedge clk) begin
    if (err_hit && !test_error) begin
      fail_addr <= addr;
    end
  end

endmodule

`default_nettype wire

// ==== memtest.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// memory tester top level
// sequencer, bus master, checker, indicators
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

`include "memtest_macros.svh"

module memtest (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  start,
  output logic                  wb_cyc,
  output logic                  wb_stb,
  output logic                  wb_we,
  output logic [`MT_ADDR_W-1:0] wb_adr,
  output logic [`MT_DATA_W-1:0] wb_dat_o,
  input  logic [`MT_DATA_W-1:0] wb_dat_i,
  input  logic                  wb_ack,
  output logic                  test_ended,
  output logic                  test_error,
  output logic [`MT_ERR_W-1:0]  err_count,
  output logic [`MT_ADDR_W-1:0] fail_addr,
  output logic                  heartbeat
);

  import memtest_pkg::*;

  logic                  acc_req;
  logic                  acc_we;
  logic                  acc_done;
  logic                  acc_timed_out;
  logic                  pass_start;
  logic                  inverted;
  logic                  checking;
  logic                  busy;
  logic                  run_clear;
  logic                  last_addr;
  logic [`MT_ADDR_W-1:0] addr;
  mt_word_u              wdata;
  mt_word_u              rdata;
  logic [`MT_HB_W-1:0]   hb_cnt;

  assign run_clear = pass_start & ~busy;  // start accepted from idle or done

  test_seq_fsm u_seq (
    .clk        (clk),
    .rst_n      (rst_n),
    .start      (start),
    .last_addr  (last_addr),
    .acc_done   (acc_done),
    .acc_req    (acc_req),
    .acc_we     (acc_we),
    .pass_start (pass_start),
    .inverted   (inverted),
    .checking   (checking),
    .busy       (busy),
    .ended      (test_ended)
  );

  addr_counter u_addr (
    .clk       (clk),
    .rst_n     (rst_n),
    .clear     (pass_start),
    .step      (acc_done),
    .addr      (addr),
    .last_addr (last_addr)
  );

  wb_master u_wbm (
    .clk       (clk),
    .rst_n     (rst_n),
    .req       (acc_req),
    .we        (acc_we),
    .addr      (addr),
    .wdata     (wdata),
    .done      (acc_done),
    .timed_out (acc_timed_out),
    .rdata     (rdata),
    .wb_cyc    (wb_cyc),
    .wb_stb    (wb_stb),
    .wb_we     (wb_we),
    .wb_adr    (wb_adr),
    .wb_dat_o  (wb_dat_o),
    .wb_dat_i  (wb_dat_i),
    .wb_ack    (wb_ack)
  );

  pattern_engine u_pat (
    .clk        (clk),
    .rst_n      (rst_n),
    .clear      (run_clear),
    .addr       (addr),
    .inverted   (inverted),
    .checking   (checking),
    .acc_done   (acc_done),
    .timed_out  (acc_timed_out),
    .rdata      (rdata),
    .wdata      (wdata),
    .err_count  (err_count),
    .test_error (test_error),
    .fail_addr  (fail_addr)
  );

  // free-running heartbeat
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      hb_cnt <= '0;
    end else begin
      hb_cnt <= hb_cnt + 1'b1;
    end
  end

  assign heartbeat = hb_cnt[`MT_HB_W-1];

endmodule

`default_nettype wire

// ==== wb_sram_model.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// wishbone slave memory for the testbench
// stuck data bits, slow ack, dropped ack
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

`include "memtest_macros.svh"

module wb_sram_model (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  cyc,
  input  logic                  stb,
  input  logic                  we,
  input  logic [`MT_ADDR_W-1:0] adr,
  input  logic [`MT_DATA_W-1:0] dat_w,
  output logic [`MT_DATA_W-1:0] dat_r,
  output logic                  ack,
  input  logic [`MT_DATA_W-1:0] stuck_mask,
  input  logic [`MT_DATA_W-1:0] stuck_val,
  input  logic [`MT_ADDR_W-1:0] fault_addr,
  input  logic [3:0]            ack_delay,
  input  logic                  drop_ack
);

  logic [`MT_DATA_W-1:0] mem [0:(1 << `MT_ADDR_W)-1];
  logic [3:0]            wait_cnt;
  logic                  hold;

  assign hold = drop_ack && (adr == fault_addr);  // this address never answers

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ack      <= 1'b0;
      wait_cnt <= '0;
    end else begin
      ack <= 1'b0;
      if (cyc && stb && !ack) begin
        if (wait_cnt < ack_delay) begin
          wait_cnt <= wait_cnt + 1'b1;
        end else if (!hold) begin
          ack      <= 1'b1;
          wait_cnt <= '0;
          if (we) begin
            mem[adr] <= dat_w;
          end else begin
            dat_r <= (mem[adr] & ~stuck_mask) | (stuck_val & stuck_mask);
          end
        end
      end else if (!cyc) begin
        wait_cnt <= '0;
      end
    end
  end

endmodule

`default_nettype wire

// ==== tb_memtest.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// memory tester testbench, table driven
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

`include "memtest_macros.svh"

module tb_memtest;

  import memtest_pkg::*;

  localparam int  NROWS = 9;
  localparam int  WORDS = 1 << `MT_ADDR_W;
  localparam int  ROW_LIMIT = 4 * WORDS * (`MT_TIMEOUT + 6);
  localparam real WATCHDOG_NS = 2.0 * NROWS * ROW_LIMIT * 4.0;

  typedef struct packed {
    logic [`MT_DATA_W-1:0] stuck_mask;
    logic [`MT_DATA_W-1:0] stuck_val;
    logic [`MT_ADDR_W-1:0] fault_addr;
    logic [3:0]            ack_delay;
    logic                  drop_ack;
    logic [`MT_ERR_W-1:0]  exp_count;
    logic [`MT_ADDR_W-1:0] exp_fail;
  } row_t;

  row_t rows [NROWS];

  logic                  clk = 1'b0;
  logic                  rst_n;
  logic                  start;
  logic                  wb_cyc, wb_stb, wb_we, wb_ack;
  logic [`MT_ADDR_W-1:0] wb_adr;
  logic [`MT_DATA_W-1:0] wb_dat_o, wb_dat_i;
  logic                  test_ended, test_error, heartbeat;
  logic [`MT_ERR_W-1:0]  err_count;
  logic [`MT_ADDR_W-1:0] fail_addr;
  logic [`MT_DATA_W-1:0] stuck_mask, stuck_val;
  logic [`MT_ADDR_W-1:0] fault_addr;
  logic [3:0]            ack_delay;
  logic                  drop_ack;
  logic [31:0]           rnd = 32'h2360_89ca;
  int                    errors = 0;
  int                    checks = 0;
  int                    acc_total = 0;  // bus accesses, one per cyc rise
  logic                  cyc_q = 1'b0;

  always #2 clk = ~clk;

  memtest UUT (
    .clk (clk), .rst_n (rst_n), .start (start),
    .wb_cyc (wb_cyc), .wb_stb (wb_stb), .wb_we (wb_we), .wb_adr (wb_adr),
    .wb_dat_o (wb_dat_o), .wb_dat_i (wb_dat_i), .wb_ack (wb_ack),
    .test_ended (test_ended), .test_error (test_error), .err_count (err_count),
    .fail_addr (fail_addr), .heartbeat (heartbeat)
  );

  wb_sram_model tb_sram (
    .clk (clk), .rst_n (rst_n), .cyc (wb_cyc), .stb (wb_stb), .we (wb_we),
    .adr (wb_adr), .dat_w (wb_dat_o), .dat_r (wb_dat_i), .ack (wb_ack),
    .stuck_mask (stuck_mask), .stuck_val (stuck_val), .fault_addr (fault_addr),
    .ack_delay (ack_delay), .drop_ack (drop_ack)
  );

  always @(posedge clk) begin
    cyc_q <= wb_cyc;
    if (wb_cyc && !cyc_q) acc_total <= acc_total + 1;
  end

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // tag A5 over the address, inverted for the second fill
  function automatic mt_word_u pattern_word(input int a, input logic inv);
    mt_word_u w;
    w.f.tag  = 8'hA5;
    w.f.echo = 24'(a);
    if (inv) w.raw = ~w.raw;
    return w;
  endfunction

  task automatic check_count(input string name, input logic [`MT_ERR_W-1:0] got, exp);
    checks++;
    if (got !== exp) begin
      $display("MISMATCH t=%0t %s: got %0d expected %0d", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_flag(input string name, input logic got, exp);
    checks++;
    if (got !== exp) begin
      $display("MISMATCH t=%0t %s: got %b expected %b", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_addr(input string name, input logic [`MT_ADDR_W-1:0] got, exp);
    checks++;
    if (got !== exp) begin
      $display("MISMATCH t=%0t %s: got %0d expected %0d", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic check_word(input string name, input mt_word_u got, exp);
    checks++;
    if (got !== exp) begin
      $display("MISMATCH t=%0t %s: got %h expected %h", $time, name, got.raw, exp.raw);
      errors++;
    end
  endtask

  // fills a row and walks the four passes to get its expected results
  task automatic set_row(input int i, input logic [31:0] mask, val,
                         input logic [`MT_ADDR_W-1:0] faddr, input logic [3:0] delay,
                         input logic drop);
    mt_word_u    exp_w;
    logic [31:0] rd;
    logic        seen;
    rows[i].stuck_mask = mask;
    rows[i].stuck_val  = val;
    rows[i].fault_addr = faddr;
    rows[i].ack_delay  = delay;
    rows[i].drop_ack   = drop;
    rows[i].exp_count  = '0;
    rows[i].exp_fail   = '0;
    seen = 1'b0;
    for (int p = 0; p < 4; p++) begin
      for (int a = 0; a < WORDS; a++) begin
        exp_w = pattern_word(a, p >= 2);
        rd    = (exp_w.raw & ~mask) | (val & mask);
        if ((drop && a == faddr) || (p % 2 == 1 && rd != exp_w.raw)) begin
          rows[i].exp_count = rows[i].exp_count + 1'b1;
          if (!seen) rows[i].exp_fail = a[`MT_ADDR_W-1:0];
          seen = 1'b1;
        end
      end
    end
  endtask

  task automatic build_table;
    set_row(0, 32'h0, 32'h0, 0, 0, 0);                 // clean
    set_row(1, 32'h1, 32'h0, 0, 0, 0);                 // bit 0 stuck low
    set_row(2, 32'h8000_0000, 32'hffff_ffff, 0, 0, 0);  // bit 31 stuck high
    set_row(3, 32'h1, 32'h0, 0, 2, 0);                 // row 1, slow ack
    set_row(4, 32'h0, 32'h0, 0, 3, 0);
    set_row(5, 32'h0, 32'h0, 37, 1, 1);                // dropped ack
    rnd = xorshift(rnd);
    set_row(6, 32'h1 << rnd[4:0], rnd, 0, rnd[9:8], 0);
    rnd = xorshift(rnd);
    set_row(7, rnd & xorshift(rnd), xorshift(rnd), 0, rnd[13:12], 0);
    set_row(8, 32'h0, 32'h0, 0, 0, 1);                 // first word never answers
  endtask

  task automatic run_row(input int i);
    int cycles;
    int err_before;
    int acc_before;
    err_before = errors;
    @(negedge clk);
    acc_before = acc_total;
    stuck_mask = rows[i].stuck_mask;
    stuck_val  = rows[i].stuck_val;
    fault_addr = rows[i].fault_addr;
    ack_delay  = rows[i].ack_delay;
    drop_ack   = rows[i].drop_ack;
    start      = 1'b1;
    @(negedge clk);
    start = 1'b0;
    check_count("err_count after start", err_count, '0);
    check_flag("test_error after start", test_error, 1'b0);
    check_flag("test_ended after start", test_ended, 1'b0);
    repeat (20) @(negedge clk);
    start = 1'b1;  // should be ignored mid-run
    @(negedge clk);
    start  = 1'b0;
    cycles = 0;
    while (!test_ended && cycles < ROW_LIMIT) begin
      @(negedge clk);
      cycles++;
    end
    if (!test_ended) begin
      $display("row %0d: test_ended never rose", i);
      errors++;
    end
    check_count("err_count", err_count, rows[i].exp_count);
    check_flag("test_error", test_error, rows[i].exp_count != 0);
    if (rows[i].exp_count != 0) check_addr("fail_addr", fail_addr, rows[i].exp_fail);
    check_flag("wb_cyc", wb_cyc, 1'b0);
    // one access per word and pass, none added by the mid-run start
    check_count("bus accesses", `MT_ERR_W'(acc_total - acc_before), `MT_ERR_W'(4 * WORDS));
    if (!rows[i].drop_ack) begin
      for (int a = 0; a < WORDS; a++) begin
        check_word($sformatf("tb_sram.mem[%0d]", a), tb_sram.mem[a], pattern_word(a, 1'b1));
      end
    end
    $display("row %0d: %s (err_count %0d)", i, (errors == err_before) ? "ok" : "wrong",
             err_count);
  endtask

  initial begin
    logic hb_first;
    logic hb_moved;
    rst_n      = 1'b0;
    start      = 1'b0;
    stuck_mask = '0;
    stuck_val  = '0;
    fault_addr = '0;
    ack_delay  = '0;
    drop_ack   = 1'b0;
    build_table();
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    check_flag("wb_cyc", wb_cyc, 1'b0);
    check_flag("wb_stb", wb_stb, 1'b0);
    check_flag("wb_we", wb_we, 1'b0);
    check_flag("test_ended", test_ended, 1'b0);
    check_flag("test_error", test_error, 1'b0);
    check_count("err_count", err_count, '0);
    hb_first = heartbeat;
    hb_moved = 1'b0;
    repeat (1 << `MT_HB_W) begin
      @(negedge clk);
      if (heartbeat !== hb_first) hb_moved = 1'b1;
    end
    checks++;
    if (!hb_moved) begin
      $display("heartbeat did not toggle after reset");
      errors++;
    end
    for (int i = 0; i < NROWS; i++) begin
      run_row(i);
    end
    $display("rows %0d, checks %0d, mismatches %0d", NROWS, checks, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

  // whole-run limit
  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired before all rows finished");
    $display(">>> FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+.
memtest_pkg.sv
test_seq_fsm.sv
addr_counter.sv
wb_master.sv
pattern_engine.sv
memtest.sv
wb_sram_model.sv
tb_memtest.sv
